// File: list.f
source/riscv_ex_pkg.sv
source/riscv_alu.sv
source/riscv_bu.sv
source/riscv_mul.sv
source/riscv_ex.sv
testbench/tb_clock.sv
testbench/tb_riscv_ex.sv

// File: source/riscv_alu.sv
`timescale 1ns/1ns

module riscv_alu (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ex_stall,
  input  logic                 id_bubble,
  input  logic                 bu_flush,
  input  riscv_ex_pkg::instr_t id_instr,
  input  riscv_ex_pkg::xlen_t  id_pc,
  input  riscv_ex_pkg::xlen_t  opA,
  input  riscv_ex_pkg::xlen_t  opB,
  output riscv_ex_pkg::xlen_t  alu_r,
  output logic                 alu_bubble
);
  import riscv_ex_pkg::*;

  // Instruction fields
  opcode_t    opcode;
  funct3_t    funct3;
  funct7_t    funct7;
  logic [4:0] shamt;

  // Decode
  logic       is_op;
  logic       claim;

  // Partial results
  logic       lt_s;
  logic       lt_u;
  xlen_t      sra_r;
  xlen_t      op_r;
  xlen_t      nxt_r;

  assign opcode = id_instr[6:0];
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];

  // Immediate forms carry the shift amount in opB as well
  assign shamt = opB[4:0];

  // Register-register ops, MUL goes elsewhere
  assign is_op = (opcode == OPC_OP) && (funct7 != FUNCT7_MULDIV);

  always_comb
  begin
    claim = 1'b0;
    case (opcode)
      OPC_OPIMM,
      OPC_LUI,
      OPC_AUIPC,
      OPC_JAL,
      OPC_JALR: claim = 1'b1;
      default:  claim = is_op;
    endcase
  end

  ////////////////////////////////////////
  // Integer operations
  ////////////////////////////////////////

  assign lt_s  = $signed(opA) < $signed(opB);
  assign lt_u  = opA < opB;
  // Arithmetic shift kept apart to stay signed
  assign sra_r = $signed(opA) >>> shamt;

  always_comb
  begin
    case (funct3)
      // SUB only exists in the register form
      F3_ADD:  op_r = (is_op && funct7 == FUNCT7_ALT) ? opA - opB : opA + opB;
      F3_SLL:  op_r = opA << shamt;
      F3_SLT:  op_r = {{(XLEN-1){1'b0}}, lt_s};
      F3_SLTU: op_r = {{(XLEN-1){1'b0}}, lt_u};
      F3_XOR:  op_r = opA ^ opB;
      F3_SR:   op_r = (funct7 == FUNCT7_ALT) ? sra_r : opA >> shamt;
      F3_OR:   op_r = opA | opB;
      default: op_r = opA & opB;
    endcase
  end

  // Upper immediates and link value
  always_comb
  begin
    case (opcode)
      OPC_LUI:   nxt_r = opB;
      OPC_AUIPC: nxt_r = id_pc + opB;
      OPC_JAL,
      OPC_JALR:  nxt_r = id_pc + xlen_t'(4);
      default:   nxt_r = op_r;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Bubble for foreign, empty or killed slots
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      alu_bubble <= 1'b1;
    else if (!ex_stall)
      alu_bubble <= !claim || id_bubble || bu_flush;
  end

  always_ff @(posedge clk)
  begin
    if (!ex_stall)
      alu_r <= nxt_r;
  end

endmodule

// File: source/riscv_bu.sv
`timescale 1ns/1ns

module riscv_bu (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ex_stall,
  input  logic                 id_bubble,
  input  riscv_ex_pkg::instr_t id_instr,
  input  riscv_ex_pkg::xlen_t  id_pc,
  input  riscv_ex_pkg::xlen_t  opA,
  input  riscv_ex_pkg::xlen_t  opB,
  input  riscv_ex_pkg::bp_t    id_bp_predict,
  output riscv_ex_pkg::xlen_t  bu_nxt_pc,
  output logic                 bu_flush,
  output logic                 bu_bp_btaken,
  output logic                 bu_bp_update,
  output riscv_ex_pkg::bp_t    bu_bp_predict
);
  import riscv_ex_pkg::*;

  opcode_t opcode;
  funct3_t funct3;

  // Offsets from the instruction word
  xlen_t   imm_b;
  xlen_t   imm_j;

  logic    is_branch;
  logic    is_jal;
  logic    is_jalr;
  logic    valid;
  logic    cond;
  logic    taken;
  logic    mispredict;
  xlen_t   target;
  bp_t     bp_nxt;

  assign opcode = id_instr[6:0];
  assign funct3 = id_instr[14:12];

  assign imm_b = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
  assign imm_j = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20], id_instr[30:21], 1'b0};

  assign is_branch = (opcode == OPC_BRANCH);
  assign is_jal    = (opcode == OPC_JAL);
  assign is_jalr   = (opcode == OPC_JALR);

  // Slot after a flush is dead
  assign valid = !id_bubble && !bu_flush;

  ////////////////////////////////////////
  // Condition and target
  ////////////////////////////////////////

  // opB holds rs2 here
  always_comb
  begin
    case (funct3)
      F3_BEQ:  cond = (opA == opB);
      F3_BNE:  cond = (opA != opB);
      F3_BLT:  cond = $signed(opA) <  $signed(opB);
      F3_BGE:  cond = $signed(opA) >= $signed(opB);
      F3_BLTU: cond = opA <  opB;
      F3_BGEU: cond = opA >= opB;
      default: cond = 1'b0;
    endcase
  end

  // Jumps are always taken
  assign taken = is_branch ? cond : (is_jal || is_jalr);

  always_comb
  begin
    if (is_jalr)
      target = (opA + opB) & ~xlen_t'(1);
    else if (is_jal)
      target = id_pc + imm_j;
    else if (is_branch && cond)
      target = id_pc + imm_b;
    else
      target = id_pc + xlen_t'(4);
  end

  // JALR target is never predicted
  assign mispredict = (is_branch && (cond != id_bp_predict[1])) ||
                      (is_jal && !id_bp_predict[1]) ||
                      is_jalr;

  // Saturating counter step
  always_comb
  begin
    bp_nxt = id_bp_predict;
    if (is_branch)
    begin
      if (cond && id_bp_predict != BP_STRONG_T)
        bp_nxt = id_bp_predict + 2'b01;
      else if (!cond && id_bp_predict != BP_STRONG_NT)
        bp_nxt = id_bp_predict - 2'b01;
    end
  end

  ////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bu_flush     <= 1'b0;
      bu_bp_btaken <= 1'b0;
      bu_bp_update <= 1'b0;
    end
    else if (!ex_stall)
    begin
      bu_flush     <= valid && mispredict;
      bu_bp_btaken <= valid && taken;
      // Predictor trains on conditional branches only
      bu_bp_update <= valid && is_branch;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!ex_stall)
    begin
      bu_nxt_pc     <= target;
      bu_bp_predict <= bp_nxt;
    end
  end

  // A flush always kills the next slot
  a_flush_single: assert property (
    @(posedge clk) disable iff (!rstn)
    (bu_flush && !ex_stall) |=> !bu_flush
  );

endmodule

// File: source/riscv_ex.sv
`timescale 1ns/1ns

module riscv_ex (
  input  logic                 clk,
  input  logic                 rstn,

  // Back-pressure
  input  logic                 wb_stall,
  output logic                 ex_stall,

  // Program counter and branch resolution
  input  riscv_ex_pkg::xlen_t  id_pc,
  output riscv_ex_pkg::xlen_t  ex_pc,
  output riscv_ex_pkg::xlen_t  bu_nxt_pc,
  output logic                 bu_flush,
  output logic                 bu_bp_btaken,
  output logic                 bu_bp_update,
  input  riscv_ex_pkg::bp_t    id_bp_predict,
  output riscv_ex_pkg::bp_t    bu_bp_predict,

  // Instruction
  input  logic                 id_bubble,
  input  riscv_ex_pkg::instr_t id_instr,
  output logic                 ex_bubble,
  output riscv_ex_pkg::instr_t ex_instr,

  // Operand selects from decode
  input  logic                 id_userf_opA,
  input  logic                 id_userf_opB,
  input  logic                 id_bypex_opA,
  input  logic                 id_bypex_opB,
  input  logic                 id_bypmem_opA,
  input  logic                 id_bypmem_opB,
  input  logic                 id_bypwb_opA,
  input  logic                 id_bypwb_opB,

  // Operand values
  input  riscv_ex_pkg::xlen_t  id_opA,
  input  riscv_ex_pkg::xlen_t  id_opB,
  input  riscv_ex_pkg::xlen_t  rf_srcv1,
  input  riscv_ex_pkg::xlen_t  rf_srcv2,
  input  riscv_ex_pkg::xlen_t  mem_r,
  input  riscv_ex_pkg::xlen_t  wb_r,

  // Stage result
  output riscv_ex_pkg::xlen_t  ex_r
);
  import riscv_ex_pkg::*;

  xlen_t opA;
  xlen_t opB;

  // Unit outputs
  xlen_t alu_r;
  xlen_t mul_r;
  logic  alu_bubble;
  logic  mul_bubble;
  logic  mul_stall;

  // Bypass priority EX, MEM, WB, then register file, then decode value
  function automatic xlen_t pick_operand(
    input logic  byp_ex,
    input logic  byp_mem,
    input logic  byp_wb,
    input logic  use_rf,
    input xlen_t v_ex,
    input xlen_t v_mem,
    input xlen_t v_wb,
    input xlen_t v_rf,
    input xlen_t v_id
  );
    if (byp_ex)
      return v_ex;
    else if (byp_mem)
      return v_mem;
    else if (byp_wb)
      return v_wb;
    else if (use_rf)
      return v_rf;
    else
      return v_id;
  endfunction

  ////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      ex_pc <= PC_INIT;
    else if (!ex_stall)
      ex_pc <= id_pc;
  end

  always_ff @(posedge clk)
  begin
    if (!ex_stall)
      ex_instr <= id_instr;
  end

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  assign opA = pick_operand(id_bypex_opA, id_bypmem_opA, id_bypwb_opA, id_userf_opA,
                            ex_r, mem_r, wb_r, rf_srcv1, id_opA);
  assign opB = pick_operand(id_bypex_opB, id_bypmem_opB, id_bypwb_opB, id_userf_opB,
                            ex_r, mem_r, wb_r, rf_srcv2, id_opB);

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  riscv_alu u_alu (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .bu_flush   (bu_flush),
    .id_instr   (id_instr),
    .id_pc      (id_pc),
    .opA        (opA),
    .opB        (opB),
    .alu_r      (alu_r),
    .alu_bubble (alu_bubble)
  );

  // Branch target, flush and predictor update
  riscv_bu u_bu (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .id_pc         (id_pc),
    .opA           (opA),
    .opB           (opB),
    .id_bp_predict (id_bp_predict),
    .bu_nxt_pc     (bu_nxt_pc),
    .bu_flush      (bu_flush),
    .bu_bp_btaken  (bu_bp_btaken),
    .bu_bp_update  (bu_bp_update),
    .bu_bp_predict (bu_bp_predict)
  );

  riscv_mul u_mul (
    .clk        (clk),
    .rstn       (rstn),
    .wb_stall   (wb_stall),
    .id_bubble  (id_bubble),
    .bu_flush   (bu_flush),
    .id_instr   (id_instr),
    .opA        (opA),
    .opB        (opB),
    .mul_r      (mul_r),
    .mul_bubble (mul_bubble),
    .mul_stall  (mul_stall)
  );

  // Merge into one result, plain branches add nothing
  assign ex_bubble = alu_bubble & mul_bubble;
  assign ex_stall  = wb_stall | mul_stall;
  assign ex_r      = mul_bubble ? alu_r : mul_r;

  // At most one unit owns the result slot
  a_one_result: assert property (
    @(posedge clk) disable iff (!rstn)
    !(!alu_bubble && !mul_bubble)
  );

endmodule

// File: source/riscv_ex_pkg.sv
package riscv_ex_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////

  // Data path and instruction widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Data words and program counters
  typedef logic [XLEN-1:0] xlen_t;

  // Raw instruction word
  typedef logic [ILEN-1:0] instr_t;

  // Predictor counter, bit 1 means predicted taken
  typedef logic [1:0] bp_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Saturation limits of the predictor counter
  localparam bp_t BP_STRONG_NT = 2'b00;
  localparam bp_t BP_STRONG_T  = 2'b11;

  // Program counter after reset
  localparam xlen_t PC_INIT = 32'h0000_0200;

  ////////////////////////////////////////
  // Multiplier timing
  ////////////////////////////////////////

  // Cycles a MUL occupies the stage
  localparam int MUL_LATENCY = 3;

  // Busy counter, loaded so that the stall lasts MUL_LATENCY-1 cycles
  typedef logic [$clog2(MUL_LATENCY)-1:0] mul_cnt_t;
  localparam mul_cnt_t MUL_CNT_LOAD = mul_cnt_t'(MUL_LATENCY - 2);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,
    MUL_DONE
  } mul_state_t;

  ////////////////////////////////////////
  // Opcodes and function codes
  ////////////////////////////////////////

  // Major opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // M extension and SUB/SRA selectors
  localparam funct7_t FUNCT7_MULDIV = 7'b0000001;
  localparam funct7_t FUNCT7_ALT    = 7'b0100000;

  // Integer ops
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

// File: source/riscv_mul.sv
`timescale 1ns/1ns

module riscv_mul (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 wb_stall,
  input  logic                 id_bubble,
  input  logic                 bu_flush,
  input  riscv_ex_pkg::instr_t id_instr,
  input  riscv_ex_pkg::xlen_t  opA,
  input  riscv_ex_pkg::xlen_t  opB,
  output riscv_ex_pkg::xlen_t  mul_r,
  output logic                 mul_bubble,
  output logic                 mul_stall
);
  import riscv_ex_pkg::*;

  mul_state_t state;
  mul_cnt_t   cnt;
  logic       is_mul;
  logic       accept;

  // Captured operands and their low product
  xlen_t      src_a;
  xlen_t      src_b;
  xlen_t      prod_lo;

  assign is_mul = (id_instr[6:0] == OPC_OP) && (id_instr[31:25] == FUNCT7_MULDIV);

  // Same as an unstalled stage edge
  assign accept = is_mul && !id_bubble && !bu_flush && !wb_stall && (state != MUL_BUSY);

  assign prod_lo = src_a * src_b;

  assign mul_stall  = (state == MUL_BUSY);
  assign mul_bubble = (state != MUL_DONE);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state <= MUL_IDLE;
      cnt   <= '0;
    end
    else if (!wb_stall)
    begin
      case (state)
        MUL_BUSY:
          if (cnt == '0)
            state <= MUL_DONE;
          else
            cnt <= cnt - 1'b1;
        // Back-to-back MUL leaves DONE straight for BUSY
        default:
          if (accept)
          begin
            state <= MUL_BUSY;
            cnt   <= MUL_CNT_LOAD;
          end
          else
            state <= MUL_IDLE;
      endcase
    end
  end

  // Operand capture and result
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      src_a <= opA;
      src_b <= opB;
    end
    if (!wb_stall && state == MUL_BUSY && cnt == '0)
      mul_r <= prod_lo;
  end

  a_no_idle_stall: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == MUL_IDLE) |-> !mul_stall
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rstn
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial
  begin
    clk = 1'b0;
    forever
      #HALF_PERIOD clk = ~clk;
  end

  // Low over the first two rising edges, released on a falling edge
  initial
  begin
    rstn = 1'b0;
    repeat (2) @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// File: testbench/tb_riscv_ex.sv
`timescale 1ns/1ns

module tb_riscv_ex;
  import riscv_ex_pkg::*;

  localparam int SEED          = 29365;
  localparam int NUM_SLOTS     = 2000;
  localparam int STALL_TIMEOUT = 32;
  localparam int RESET_TIMEOUT = 10;

  // Instruction kinds of the stimulus
  localparam int K_OP     = 0;
  localparam int K_OPIMM  = 1;
  localparam int K_LUI    = 2;
  localparam int K_AUIPC  = 3;
  localparam int K_MUL    = 4;
  localparam int K_BRANCH = 5;
  localparam int K_JAL    = 6;
  localparam int K_JALR   = 7;

  logic   clk;
  logic   rstn;
  logic   wb_stall;
  logic   ex_stall;
  xlen_t  id_pc;
  xlen_t  ex_pc;
  xlen_t  bu_nxt_pc;
  logic   bu_flush;
  logic   bu_bp_btaken;
  logic   bu_bp_update;
  bp_t    id_bp_predict;
  bp_t    bu_bp_predict;
  logic   id_bubble;
  instr_t id_instr;
  logic   ex_bubble;
  instr_t ex_instr;
  logic   id_userf_opA;
  logic   id_userf_opB;
  logic   id_bypex_opA;
  logic   id_bypex_opB;
  logic   id_bypmem_opA;
  logic   id_bypmem_opB;
  logic   id_bypwb_opA;
  logic   id_bypwb_opB;
  xlen_t  id_opA;
  xlen_t  id_opB;
  xlen_t  rf_srcv1;
  xlen_t  rf_srcv2;
  xlen_t  mem_r;
  xlen_t  wb_r;
  xlen_t  ex_r;

  // Current decode slot with selects as {ex, mem, wb, rf}
  int         s_kind;
  instr_t     s_instr;
  funct3_t    s_f3;
  logic       s_alt;
  xlen_t      s_off;
  xlen_t      s_pc;
  logic       s_bubble;
  bp_t        s_pred;
  logic [3:0] s_sel_a;
  logic [3:0] s_sel_b;
  xlen_t      s_id_a;
  xlen_t      s_id_b;
  xlen_t      s_rf1;
  xlen_t      s_rf2;
  xlen_t      s_mem;
  xlen_t      s_wb;

  // Reference model of the stage outputs
  xlen_t  m_ex_r;
  logic   m_ex_bubble;
  xlen_t  m_ex_pc;
  instr_t m_ex_instr;
  logic   m_instr_known;
  logic   m_flush;
  logic   m_btaken;
  logic   m_update;
  xlen_t  m_nxt_pc;
  logic   m_nxt_chk;
  bp_t    m_bp;
  logic   m_bp_chk;
  int     m_mul_cnt;
  xlen_t  m_mul_prod;

  int mismatch_cnt;
  int timeout_cnt;

  tb_clock clock_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  riscv_ex riscv_ex_i (
    .clk           (clk),
    .rstn          (rstn),
    .wb_stall      (wb_stall),
    .ex_stall      (ex_stall),
    .id_pc         (id_pc),
    .ex_pc         (ex_pc),
    .bu_nxt_pc     (bu_nxt_pc),
    .bu_flush      (bu_flush),
    .bu_bp_btaken  (bu_bp_btaken),
    .bu_bp_update  (bu_bp_update),
    .id_bp_predict (id_bp_predict),
    .bu_bp_predict (bu_bp_predict),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .ex_bubble     (ex_bubble),
    .ex_instr      (ex_instr),
    .id_userf_opA  (id_userf_opA),
    .id_userf_opB  (id_userf_opB),
    .id_bypex_opA  (id_bypex_opA),
    .id_bypex_opB  (id_bypex_opB),
    .id_bypmem_opA (id_bypmem_opA),
    .id_bypmem_opB (id_bypmem_opB),
    .id_bypwb_opA  (id_bypwb_opA),
    .id_bypwb_opB  (id_bypwb_opB),
    .id_opA        (id_opA),
    .id_opB        (id_opB),
    .rf_srcv1      (rf_srcv1),
    .rf_srcv2      (rf_srcv2),
    .mem_r         (mem_r),
    .wb_r          (wb_r),
    .ex_r          (ex_r)
  );

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_xlen(input xlen_t actual, input xlen_t expected, input string what);
    if (actual !== expected)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_instr(input instr_t actual, input instr_t expected, input string what);
    if (actual !== expected)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  task automatic check_bp(input bp_t actual, input bp_t expected, input string what);
    if (actual !== expected)
    begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // ISA reference functions
  ////////////////////////////////////////

  // Small values now and then so compares hit equality
  function automatic xlen_t rand_value();
    if ($urandom_range(0, 3) == 0)
      return xlen_t'($urandom_range(0, 3));
    return xlen_t'($urandom);
  endfunction

  // First set select wins in the order ex, mem, wb, rf
  function automatic xlen_t resolve_src(input logic [3:0] sel, input xlen_t v_ex,
                                        input xlen_t v_mem, input xlen_t v_wb,
                                        input xlen_t v_rf, input xlen_t v_id);
    casez (sel)
      4'b1???: return v_ex;
      4'b01??: return v_mem;
      4'b001?: return v_wb;
      4'b0001: return v_rf;
      default: return v_id;
    endcase
  endfunction

  function automatic xlen_t alu_model(input int kind, input funct3_t f3, input logic alt,
                                      input xlen_t a, input xlen_t b, input xlen_t pc);
    if (kind == K_LUI)
      return b;
    if (kind == K_AUIPC)
      return pc + b;
    // Link value of both jumps
    if (kind == K_JAL || kind == K_JALR)
      return pc + 32'd4;
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_SR:
      begin
        // Sign fill needs a signed expression of its own
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input funct3_t f3, input xlen_t a, input xlen_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Two-bit saturating counter
  function automatic bp_t bp_step(input bp_t p, input logic taken);
    if (taken)
      return (p == 2'b11) ? p : p + 2'b01;
    return (p == 2'b00) ? p : p - 2'b01;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic new_slot();
    int          pick;
    logic [12:0] boff;
    logic [20:0] joff;
    pick    = $urandom_range(0, 15);
    s_instr = instr_t'($urandom);
    s_f3    = funct3_t'($urandom_range(0, 7));
    s_alt   = 1'b0;
    s_off   = '0;
    if (pick <= 4)
      s_kind = K_OP;
    else if (pick <= 7)
      s_kind = K_OPIMM;
    else if (pick <= 9)
      s_kind = (pick == 8) ? K_LUI : K_AUIPC;
    else if (pick <= 11)
      s_kind = K_MUL;
    else if (pick <= 13)
      s_kind = K_BRANCH;
    else
      s_kind = (pick == 14) ? K_JAL : K_JALR;
    case (s_kind)
      K_OP,
      K_OPIMM:
      begin
        // Alternate form only for SUB and arithmetic shift
        if (s_f3 == F3_SR || (s_f3 == F3_ADD && s_kind == K_OP))
          s_alt = 1'($urandom_range(0, 1));
        s_instr[6:0]   = (s_kind == K_OP) ? OPC_OP : OPC_OPIMM;
        s_instr[31:25] = s_alt ? FUNCT7_ALT : 7'b0000000;
      end
      K_MUL:
      begin
        s_f3           = F3_ADD;
        s_instr[6:0]   = OPC_OP;
        s_instr[31:25] = FUNCT7_MULDIV;
      end
      K_BRANCH:
      begin
        // No conditions at 010 and 011
        if (s_f3 == 3'b010 || s_f3 == 3'b011)
          s_f3[1] = 1'b0;
        boff           = 13'($urandom);
        boff[0]        = 1'b0;
        s_instr[31]    = boff[12];
        s_instr[30:25] = boff[10:5];
        s_instr[11:8]  = boff[4:1];
        s_instr[7]     = boff[11];
        s_instr[6:0]   = OPC_BRANCH;
        s_off          = {{19{boff[12]}}, boff};
      end
      K_JAL:
      begin
        joff           = 21'($urandom);
        joff[0]        = 1'b0;
        s_instr[31]    = joff[20];
        s_instr[30:21] = joff[10:1];
        s_instr[20]    = joff[11];
        s_instr[19:12] = joff[19:12];
        s_instr[6:0]   = OPC_JAL;
        s_off          = {{11{joff[20]}}, joff};
      end
      K_JALR:  s_instr[6:0] = OPC_JALR;
      K_LUI:   s_instr[6:0] = OPC_LUI;
      default: s_instr[6:0] = OPC_AUIPC;
    endcase
    // J-immediate occupies the funct3 bits
    if (s_kind != K_JAL)
      s_instr[14:12] = s_f3;
    s_pc     = xlen_t'($urandom) & ~xlen_t'(3);
    s_bubble = ($urandom_range(0, 11) == 0);
    s_pred   = bp_t'($urandom_range(0, 3));
    s_id_a   = rand_value();
    s_id_b   = rand_value();
    s_rf1    = rand_value();
    s_rf2    = rand_value();
    s_mem    = rand_value();
    s_wb     = rand_value();
    s_sel_a  = 4'($urandom & $urandom);
    s_sel_b  = 4'($urandom & $urandom);
    // EX bypass only when a result will be there at acceptance
    if (m_ex_bubble && m_mul_cnt == 0)
    begin
      s_sel_a[3] = 1'b0;
      s_sel_b[3] = 1'b0;
    end
  endtask

  // Whole slot held steady while back-pressure varies
  task automatic drive_inputs(input logic stall_wb);
    wb_stall      = stall_wb;
    id_pc         = s_pc;
    id_instr      = s_instr;
    id_bubble     = s_bubble;
    id_bp_predict = s_pred;
    id_opA        = s_id_a;
    id_opB        = s_id_b;
    rf_srcv1      = s_rf1;
    rf_srcv2      = s_rf2;
    mem_r         = s_mem;
    wb_r          = s_wb;
    id_bypex_opA  = s_sel_a[3];
    id_bypmem_opA = s_sel_a[2];
    id_bypwb_opA  = s_sel_a[1];
    id_userf_opA  = s_sel_a[0];
    id_bypex_opB  = s_sel_b[3];
    id_bypmem_opB = s_sel_b[2];
    id_bypwb_opB  = s_sel_b[1];
    id_userf_opB  = s_sel_b[0];
  endtask

  ////////////////////////////////////////
  // Model step on a rising edge
  ////////////////////////////////////////

  task automatic update_model(input logic stall_wb);
    xlen_t a;
    xlen_t b;
    logic  kill;
    logic  cond;
    // Back-pressure freezes everything
    if (stall_wb)
      return;
    // Slot stays with decode while a multiply is in flight
    if (m_mul_cnt != 0)
    begin
      m_mul_cnt--;
      if (m_mul_cnt == 0)
      begin
        m_ex_r      = m_mul_prod;
        m_ex_bubble = 1'b0;
      end
      return;
    end
    a    = resolve_src(s_sel_a, m_ex_r, s_mem, s_wb, s_rf1, s_id_a);
    b    = resolve_src(s_sel_b, m_ex_r, s_mem, s_wb, s_rf2, s_id_b);
    // Slot behind a flush dies
    kill = s_bubble || m_flush;
    m_ex_pc       = s_pc;
    m_ex_instr    = s_instr;
    m_instr_known = 1'b1;
    m_ex_bubble   = 1'b1;
    m_flush       = 1'b0;
    m_btaken      = 1'b0;
    m_update      = 1'b0;
    m_nxt_chk     = 1'b0;
    m_bp_chk      = 1'b0;
    if (kill)
      return;
    case (s_kind)
      K_MUL:
      begin
        m_mul_cnt  = MUL_LATENCY - 1;
        m_mul_prod = a * b;
      end
      K_BRANCH:
      begin
        // No link value, so no result
        cond      = branch_cond(s_f3, a, b);
        m_flush   = (cond != s_pred[1]);
        m_btaken  = cond;
        m_update  = 1'b1;
        m_nxt_pc  = cond ? s_pc + s_off : s_pc + 32'd4;
        m_nxt_chk = 1'b1;
        m_bp      = bp_step(s_pred, cond);
        m_bp_chk  = 1'b1;
      end
      default:
      begin
        m_ex_r      = alu_model(s_kind, s_f3, s_alt, a, b, s_pc);
        m_ex_bubble = 1'b0;
        if (s_kind == K_JAL)
        begin
          m_flush   = !s_pred[1];
          m_btaken  = 1'b1;
          m_nxt_pc  = s_pc + s_off;
          m_nxt_chk = 1'b1;
        end
        else if (s_kind == K_JALR)
        begin
          // Never predicted
          m_flush   = 1'b1;
          m_btaken  = 1'b1;
          m_nxt_pc  = (a + b) & ~xlen_t'(1);
          m_nxt_chk = 1'b1;
        end
      end
    endcase
  endtask

  task automatic check_outputs();
    check_bit(ex_bubble, m_ex_bubble, "ex_bubble");
    if (!m_ex_bubble)
      check_xlen(ex_r, m_ex_r, "ex_r");
    check_xlen(ex_pc, m_ex_pc, "ex_pc");
    if (m_instr_known)
      check_instr(ex_instr, m_ex_instr, "ex_instr");
    check_bit(bu_flush, m_flush, "bu_flush");
    check_bit(bu_bp_btaken, m_btaken, "bu_bp_btaken");
    check_bit(bu_bp_update, m_update, "bu_bp_update");
    if (m_nxt_chk)
      check_xlen(bu_nxt_pc, m_nxt_pc, "bu_nxt_pc");
    if (m_bp_chk)
      check_bp(bu_bp_predict, m_bp, "bu_bp_predict");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    int   slot;
    int   waited;
    logic wb_v;
    logic accepted;
    logic abort;
    void'($urandom(SEED));
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    abort        = 1'b0;
    // Idle decode at the reset PC
    wb_stall      = 1'b0;
    id_pc         = PC_INIT;
    id_instr      = '0;
    id_bubble     = 1'b1;
    id_bp_predict = '0;
    id_opA        = '0;
    id_opB        = '0;
    rf_srcv1      = '0;
    rf_srcv2      = '0;
    mem_r         = '0;
    wb_r          = '0;
    id_userf_opA  = 1'b0;
    id_userf_opB  = 1'b0;
    id_bypex_opA  = 1'b0;
    id_bypex_opB  = 1'b0;
    id_bypmem_opA = 1'b0;
    id_bypmem_opB = 1'b0;
    id_bypwb_opA  = 1'b0;
    id_bypwb_opB  = 1'b0;
    // Model state after reset
    m_ex_r        = '0;
    m_ex_bubble   = 1'b1;
    m_ex_pc       = PC_INIT;
    m_ex_instr    = '0;
    m_instr_known = 1'b0;
    m_flush       = 1'b0;
    m_btaken      = 1'b0;
    m_update      = 1'b0;
    m_nxt_pc      = '0;
    m_nxt_chk     = 1'b0;
    m_bp          = '0;
    m_bp_chk      = 1'b0;
    m_mul_cnt     = 0;
    m_mul_prod    = '0;

    waited = 0;
    while (rstn !== 1'b1 && waited < RESET_TIMEOUT)
    begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (rstn !== 1'b1)
    begin
      $display("reset was never released");
      timeout_cnt++;
      abort = 1'b1;
    end
    else
    begin
      // Reset values, before any rising edge out of reset
      check_xlen(ex_pc, PC_INIT, "ex_pc after reset");
      check_bit(ex_bubble, 1'b1, "ex_bubble after reset");
      check_bit(ex_stall, 1'b0, "ex_stall after reset");
      check_bit(bu_flush, 1'b0, "bu_flush after reset");
      check_bit(bu_bp_update, 1'b0, "bu_bp_update after reset");
      @(negedge clk);
    end

    for (slot = 0; slot < NUM_SLOTS && !abort; slot++)
    begin
      new_slot();
      accepted = 1'b0;
      waited   = 0;
      // Hold the slot until the stage takes it
      while (!accepted && !abort)
      begin
        wb_v = ($urandom_range(0, 9) == 0);
        drive_inputs(wb_v);
        #1;
        check_bit(ex_stall, wb_v || (m_mul_cnt != 0), "ex_stall");
        accepted = (ex_stall === 1'b0);
        @(posedge clk);
        update_model(wb_v);
        @(negedge clk);
        check_outputs();
        waited++;
        if (!accepted && waited > STALL_TIMEOUT)
        begin
          $display("ex_stall stayed high for %0d cycles, the stage is stuck", waited);
          timeout_cnt++;
          abort = 1'b1;
        end
      end
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
